// ==== include/gat_consts.svh ====
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// ======================================================================
// Bus and datapath widths
// ======================================================================
`define GAT_TOP_WIDTH          32
`define GAT_DATA_WIDTH         8
`define GAT_WH_DATA_WIDTH      20
`define GAT_NEW_FEATURE_WIDTH  32

// ======================================================================
// Fixed small graph configuration
// ======================================================================
`define GAT_NUM_FEATURE_IN     16
`define GAT_NUM_FEATURE_OUT    4
`define GAT_TOTAL_NODES        8
`define GAT_H_DEPTH            64
`define GAT_WEIGHT_DEPTH       64
`define GAT_FEAT_DEPTH         32

// Field and word-address widths
`define GAT_COL_IDX_WIDTH      4
`define GAT_ROW_LEN_WIDTH      5
`define GAT_H_ADDR_W           6
`define GAT_NODE_ADDR_W        3
`define GAT_WEIGHT_ADDR_W      6
`define GAT_FEAT_ADDR_W        5

`endif

// ==== rtl/gat_pkg.sv ====
`include "gat_consts.svh"

package gat_pkg;

  // One sparse entry of H
  typedef struct packed {
    logic signed [`GAT_DATA_WIDTH-1:0] value;
    logic [`GAT_COL_IDX_WIDTH-1:0]     col;
  } h_entry_t;

  // Row information of one node
  typedef struct packed {
    logic [`GAT_ROW_LEN_WIDTH-1:0] row_len;
    logic                          last;
  } node_info_t;

  typedef logic signed [`GAT_DATA_WIDTH-1:0]    weight_t;
  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0] acc_t;

  // Host word views with the payload in the low bits
  typedef struct packed {
    logic [`GAT_TOP_WIDTH-$bits(h_entry_t)-1:0] unused;
    h_entry_t                                   entry;
  } h_load_t;

  typedef struct packed {
    logic [`GAT_TOP_WIDTH-$bits(node_info_t)-1:0] unused;
    node_info_t                                   info;
  } node_load_t;

  typedef union packed {
    logic [`GAT_TOP_WIDTH-1:0] raw;
    h_load_t                   h;
    node_load_t                node;
  } load_word_u;

endpackage

// ==== rtl/gat_bram_store.sv ====
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_bram_store (
  input  logic                           clk,
  input  logic                           arst_n,

  input  logic [`GAT_TOP_WIDTH-1:0]      h_data_bram_din,
  input  logic                           h_data_bram_ena,
  input  logic                           h_data_bram_wea,
  input  logic [`GAT_H_ADDR_W+1:0]       h_data_bram_addra,

  input  logic [`GAT_TOP_WIDTH-1:0]      h_node_info_bram_din,
  input  logic                           h_node_info_bram_ena,
  input  logic                           h_node_info_bram_wea,
  input  logic [`GAT_NODE_ADDR_W+1:0]    h_node_info_bram_addra,

  input  logic [`GAT_TOP_WIDTH-1:0]      wgt_bram_din,
  input  logic                           wgt_bram_ena,
  input  logic                           wgt_bram_wea,
  input  logic [`GAT_WEIGHT_ADDR_W+1:0]  wgt_bram_addra,

  input  logic [`GAT_H_ADDR_W-1:0]       h_rd_addr,
  input  logic [`GAT_NODE_ADDR_W-1:0]    node_rd_addr,
  input  logic [`GAT_WEIGHT_ADDR_W-1:0]  wgt_rd_addr,
  output gat_pkg::h_entry_t              h_rd_data,
  output gat_pkg::node_info_t            node_rd_data,
  output gat_pkg::weight_t               wgt_rd_data
);
  import gat_pkg::*;

  h_entry_t   h_mem    [`GAT_H_DEPTH];
  node_info_t node_mem [`GAT_TOTAL_NODES];
  weight_t    wgt_mem  [`GAT_WEIGHT_DEPTH];

  load_word_u h_word;
  load_word_u node_word;

  logic [`GAT_H_ADDR_W-1:0]      h_wr_idx;
  logic [`GAT_NODE_ADDR_W-1:0]   node_wr_idx;
  logic [`GAT_WEIGHT_ADDR_W-1:0] wgt_wr_idx;

  // ====================================================================
  // Host write side
  // ====================================================================
  assign h_word    = h_data_bram_din;
  assign node_word = h_node_info_bram_din;

  // Byte address to word index
  assign h_wr_idx    = h_data_bram_addra[`GAT_H_ADDR_W+1:2];
  assign node_wr_idx = h_node_info_bram_addra[`GAT_NODE_ADDR_W+1:2];
  assign wgt_wr_idx  = wgt_bram_addra[`GAT_WEIGHT_ADDR_W+1:2];

  always_ff @(posedge clk) begin
    if (h_data_bram_ena && h_data_bram_wea) begin
      h_mem[h_wr_idx] <= h_word.h.entry;
    end
    if (h_node_info_bram_ena && h_node_info_bram_wea) begin
      node_mem[node_wr_idx] <= node_word.node.info;
    end
    if (wgt_bram_ena && wgt_bram_wea) begin
      wgt_mem[wgt_wr_idx] <= wgt_bram_din[`GAT_DATA_WIDTH-1:0];
    end
  end

  // ====================================================================
  // Core read side with one cycle of latency
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_rd_data    <= '0;
      node_rd_data <= '0;
      wgt_rd_data  <= '0;
    end else begin
      h_rd_data    <= h_mem[h_rd_addr];
      node_rd_data <= node_mem[node_rd_addr];
      wgt_rd_data  <= wgt_mem[wgt_rd_addr];
    end
  end

endmodule

// ==== rtl/gat_status_regs.sv ====
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_status_regs (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      h_data_bram_load_done,
  input  logic                      h_node_info_bram_load_done,
  input  logic                      wgt_bram_load_done,
  input  logic                      done,
  input  logic                      node_step,
  input  logic                      nnz_step,
  output logic                      start,
  output logic                      gat_ready,
  output logic [`GAT_TOP_WIDTH-1:0] gat_debug_1,
  output logic [`GAT_TOP_WIDTH-1:0] gat_debug_2,
  output logic [`GAT_TOP_WIDTH-1:0] gat_debug_3
);

  logic h_seen;
  logic node_seen;
  logic wgt_seen;
  logic all_seen;
  logic start_sent;
  logic busy;

  assign all_seen = h_seen & node_seen & wgt_seen;

  // ====================================================================
  // Load tracking and start
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_seen     <= 1'b0;
      node_seen  <= 1'b0;
      wgt_seen   <= 1'b0;
      start_sent <= 1'b0;
      start      <= 1'b0;
      busy       <= 1'b0;
      gat_ready  <= 1'b0;
    end else begin
      h_seen    <= h_seen | h_data_bram_load_done;
      node_seen <= node_seen | h_node_info_bram_load_done;
      wgt_seen  <= wgt_seen | wgt_bram_load_done;
      // Single start per reset
      start     <= all_seen & ~start_sent;
      if (all_seen) begin
        start_sent <= 1'b1;
      end
      if (start) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      // Sticky until reset
      gat_ready <= gat_ready | done;
    end
  end

  // Debug counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gat_debug_1 <= '0;
      gat_debug_2 <= '0;
      gat_debug_3 <= '0;
    end else begin
      if (node_step) gat_debug_1 <= gat_debug_1 + 1'b1;
      if (nnz_step) gat_debug_2 <= gat_debug_2 + 1'b1;
      if (start || busy) gat_debug_3 <= gat_debug_3 + 1'b1;
    end
  end

endmodule

// ==== rtl/gat_spmm_core.sv ====
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_spmm_core (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          start,
  output logic [`GAT_H_ADDR_W-1:0]      h_rd_addr,
  output logic [`GAT_NODE_ADDR_W-1:0]   node_rd_addr,
  output logic [`GAT_WEIGHT_ADDR_W-1:0] wgt_rd_addr,
  input  gat_pkg::h_entry_t             h_rd_data,
  input  gat_pkg::node_info_t           node_rd_data,
  input  gat_pkg::weight_t              wgt_rd_data,
  output logic                          feat_wr_en,
  output logic [`GAT_FEAT_ADDR_W-1:0]   feat_wr_addr,
  output gat_pkg::acc_t                 feat_wr_data,
  output logic                          done,
  output logic                          node_step,
  output logic                          nnz_step
);
  import gat_pkg::*;

  localparam int NF  = `GAT_NUM_FEATURE_OUT;
  localparam int JW  = $clog2(NF);
  localparam int WAW = `GAT_WEIGHT_ADDR_W;
  localparam int FAW = `GAT_FEAT_ADDR_W;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH_NODE,
    S_FETCH_ENTRY,
    S_ACCUM,
    S_WRITE,
    S_DONE
  } state_t;

  state_t                         state;
  logic [`GAT_NODE_ADDR_W-1:0]    node_idx;
  logic [`GAT_H_ADDR_W-1:0]       h_ptr;
  logic [JW-1:0]                  j;
  logic [`GAT_ROW_LEN_WIDTH-1:0]  remain;
  logic                           last_q;
  logic                           last_col;
  logic [`GAT_COL_IDX_WIDTH-1:0]  col_sel;
  logic [JW-1:0]                  j_sel;

  weight_t                        val_q;
  logic [`GAT_COL_IDX_WIDTH-1:0]  col_q;
  acc_t                           acc [NF];

  assign last_col = (j == JW'(NF - 1));

  // ====================================================================
  // Read addresses
  // ====================================================================
  // H is prefetched so h_rd_data always follows h_ptr
  assign h_rd_addr = h_ptr;

  // Look one node ahead on the final write so FETCH_NODE sees valid data
  assign node_rd_addr = (state == S_WRITE && last_col) ? node_idx + 1'b1 : node_idx;

  // Column 0 weight is requested while the entry arrives and j+1 on each later cycle
  assign col_sel     = (state == S_FETCH_ENTRY) ? h_rd_data.col : col_q;
  assign j_sel       = (state == S_FETCH_ENTRY) ? '0 : j + 1'b1;
  assign wgt_rd_addr = WAW'(col_sel * NF + j_sel);

  // ====================================================================
  // Sequencer
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= S_IDLE;
      node_idx <= '0;
      h_ptr    <= '0;
      j        <= '0;
      remain   <= '0;
      last_q   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) state <= S_FETCH_NODE;
        end
        S_FETCH_NODE: begin
          remain <= node_rd_data.row_len;
          last_q <= node_rd_data.last;
          j      <= '0;
          state  <= (node_rd_data.row_len == '0) ? S_WRITE : S_FETCH_ENTRY;
        end
        S_FETCH_ENTRY: begin
          h_ptr <= h_ptr + 1'b1;
          j     <= '0;
          state <= S_ACCUM;
        end
        S_ACCUM: begin
          j <= j + 1'b1;
          if (last_col) begin
            j      <= '0;
            remain <= remain - 1'b1;
            state  <= (remain == 1) ? S_WRITE : S_FETCH_ENTRY;
          end
        end
        S_WRITE: begin
          j <= j + 1'b1;
          if (last_col) begin
            j        <= '0;
            node_idx <= node_idx + 1'b1;
            state    <= last_q ? S_DONE : S_FETCH_NODE;
          end
        end
        S_DONE: begin
          node_idx <= '0;
          h_ptr    <= '0;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Entry latch and accumulator bank
  always_ff @(posedge clk) begin
    case (state)
      S_FETCH_NODE: begin
        for (int k = 0; k < NF; k++) begin
          acc[k] <= '0;
        end
      end
      S_FETCH_ENTRY: begin
        val_q <= h_rd_data.value;
        col_q <= h_rd_data.col;
      end
      S_ACCUM: acc[j] <= acc[j] + val_q * wgt_rd_data;
      default: ;
    endcase
  end

  // ====================================================================
  // Outputs
  // ====================================================================
  assign feat_wr_en   = (state == S_WRITE);
  assign feat_wr_addr = FAW'(node_idx * NF + j);
  assign feat_wr_data = acc[j];
  assign done         = (state == S_DONE);
  assign node_step    = (state == S_WRITE) && last_col;
  assign nnz_step     = (state == S_FETCH_ENTRY);

endmodule

// ==== rtl/gat_feat_bram.sv ====
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_feat_bram (
  input  logic                              clk,
  input  logic                              feat_wr_en,
  input  logic [`GAT_FEAT_ADDR_W-1:0]       feat_wr_addr,
  input  gat_pkg::acc_t                     feat_wr_data,
  input  logic [`GAT_FEAT_ADDR_W+1:0]       feat_bram_addrb,
  output logic [`GAT_NEW_FEATURE_WIDTH-1:0] feat_bram_dout
);
  import gat_pkg::*;

  localparam int EXT = `GAT_NEW_FEATURE_WIDTH - `GAT_WH_DATA_WIDTH;

  acc_t mem [`GAT_FEAT_DEPTH];
  acc_t rd_word;

  // Core write port
  always_ff @(posedge clk) begin
    if (feat_wr_en) begin
      mem[feat_wr_addr] <= feat_wr_data;
    end
  end

  // Host read port on a byte address
  always_ff @(posedge clk) begin
    feat_bram_dout <= {{EXT{rd_word[`GAT_WH_DATA_WIDTH-1]}}, rd_word};
  end

  assign rd_word = mem[feat_bram_addrb[`GAT_FEAT_ADDR_W+1:2]];

endmodule

// ==== rtl/gat_top_wrapper.sv ====
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_top_wrapper (
  input  logic                              clk,
  input  logic                              arst_n,

  // ====================================================================
  // Register bank
  // ====================================================================
  output logic                              gat_ready,
  output logic [`GAT_TOP_WIDTH-1:0]         gat_debug_1,
  output logic [`GAT_TOP_WIDTH-1:0]         gat_debug_2,
  output logic [`GAT_TOP_WIDTH-1:0]         gat_debug_3,
  input  logic                              h_data_bram_load_done,
  input  logic                              h_node_info_bram_load_done,
  input  logic                              wgt_bram_load_done,

  // ====================================================================
  // Memory interface
  // ====================================================================
  input  logic [`GAT_TOP_WIDTH-1:0]         h_data_bram_din,
  input  logic                              h_data_bram_ena,
  input  logic                              h_data_bram_wea,
  input  logic [`GAT_H_ADDR_W+1:0]          h_data_bram_addra,
  input  logic [`GAT_TOP_WIDTH-1:0]         h_node_info_bram_din,
  input  logic                              h_node_info_bram_ena,
  input  logic                              h_node_info_bram_wea,
  input  logic [`GAT_NODE_ADDR_W+1:0]       h_node_info_bram_addra,
  input  logic [`GAT_TOP_WIDTH-1:0]         wgt_bram_din,
  input  logic                              wgt_bram_ena,
  input  logic                              wgt_bram_wea,
  input  logic [`GAT_WEIGHT_ADDR_W+1:0]     wgt_bram_addra,
  input  logic [`GAT_FEAT_ADDR_W+1:0]       feat_bram_addrb,
  output logic [`GAT_NEW_FEATURE_WIDTH-1:0] feat_bram_dout
);
  import gat_pkg::*;

  logic [`GAT_H_ADDR_W-1:0]      h_rd_addr;
  logic [`GAT_NODE_ADDR_W-1:0]   node_rd_addr;
  logic [`GAT_WEIGHT_ADDR_W-1:0] wgt_rd_addr;
  h_entry_t                      h_rd_data;
  node_info_t                    node_rd_data;
  weight_t                       wgt_rd_data;

  logic                          start;
  logic                          done;
  logic                          node_step;
  logic                          nnz_step;
  logic                          feat_wr_en;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_wr_addr;
  acc_t                          feat_wr_data;

  gat_bram_store u_store (
    .clk                    (clk),
    .arst_n                 (arst_n),
    .h_data_bram_din        (h_data_bram_din),
    .h_data_bram_ena        (h_data_bram_ena),
    .h_data_bram_wea        (h_data_bram_wea),
    .h_data_bram_addra      (h_data_bram_addra),
    .h_node_info_bram_din   (h_node_info_bram_din),
    .h_node_info_bram_ena   (h_node_info_bram_ena),
    .h_node_info_bram_wea   (h_node_info_bram_wea),
    .h_node_info_bram_addra (h_node_info_bram_addra),
    .wgt_bram_din           (wgt_bram_din),
    .wgt_bram_ena           (wgt_bram_ena),
    .wgt_bram_wea           (wgt_bram_wea),
    .wgt_bram_addra         (wgt_bram_addra),
    .h_rd_addr              (h_rd_addr),
    .node_rd_addr           (node_rd_addr),
    .wgt_rd_addr            (wgt_rd_addr),
    .h_rd_data              (h_rd_data),
    .node_rd_data           (node_rd_data),
    .wgt_rd_data            (wgt_rd_data)
  );

  gat_status_regs u_status (
    .clk                        (clk),
    .arst_n                     (arst_n),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .done                       (done),
    .node_step                  (node_step),
    .nnz_step                   (nnz_step),
    .start                      (start),
    .gat_ready                  (gat_ready),
    .gat_debug_1                (gat_debug_1),
    .gat_debug_2                (gat_debug_2),
    .gat_debug_3                (gat_debug_3)
  );

  gat_spmm_core u_core (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .h_rd_addr    (h_rd_addr),
    .node_rd_addr (node_rd_addr),
    .wgt_rd_addr  (wgt_rd_addr),
    .h_rd_data    (h_rd_data),
    .node_rd_data (node_rd_data),
    .wgt_rd_data  (wgt_rd_data),
    .feat_wr_en   (feat_wr_en),
    .feat_wr_addr (feat_wr_addr),
    .feat_wr_data (feat_wr_data),
    .done         (done),
    .node_step    (node_step),
    .nnz_step     (nnz_step)
  );

  gat_feat_bram u_feat (
    .clk             (clk),
    .feat_wr_en      (feat_wr_en),
    .feat_wr_addr    (feat_wr_addr),
    .feat_wr_data    (feat_wr_data),
    .feat_bram_addrb (feat_bram_addrb),
    .feat_bram_dout  (feat_bram_dout)
  );

endmodule

// ==== tests/gat_clk_gen.sv ====
`timescale 1ns/1ps

module gat_clk_gen (
  input  logic rst_req,
  output logic clk,
  output logic arst_n
);

  logic [4:0] rst_cnt;

  // 20 ns period
  initial begin
    clk     = 1'b0;
    rst_cnt = 5'd16;
  end

  always #10 clk = ~clk;

  // Reset held for 16 rising edges after power-up or after a request
  always @(posedge clk) begin
    if (rst_req) begin
      rst_cnt <= 5'd16;
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign arst_n = (rst_cnt == '0);

endmodule

// ==== tests/gat_asserts.sv ====
`timescale 1ns/1ps

module gat_asserts (
  input logic clk,
  input logic arst_n,
  input logic gat_ready,
  input logic start,
  input logic feat_wr_en,
  input logic h_data_bram_load_done,
  input logic h_node_info_bram_load_done,
  input logic wgt_bram_load_done
);

  int   fail_count = 0;
  logic h_seen;
  logic node_seen;
  logic wgt_seen;

  // Load-done history since the last reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_seen    <= 1'b0;
      node_seen <= 1'b0;
      wgt_seen  <= 1'b0;
    end else begin
      h_seen    <= h_seen | h_data_bram_load_done;
      node_seen <= node_seen | h_node_info_bram_load_done;
      wgt_seen  <= wgt_seen | wgt_bram_load_done;
    end
  end

  // ====================================================================
  // Properties
  // ====================================================================
  ready_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    gat_ready |=> gat_ready)
    else begin
      $error("gat_ready fell without a reset");
      fail_count++;
    end

  start_single: assert property (@(posedge clk) disable iff (!arst_n)
    start |=> !start)
    else begin
      $error("start was high for two cycles in a row");
      fail_count++;
    end

  no_write_when_ready: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(feat_wr_en) |-> !gat_ready)
    else begin
      $error("feature write started while gat_ready was high");
      fail_count++;
    end

  ready_after_loads: assert property (@(posedge clk) disable iff (!arst_n)
    gat_ready |-> (h_seen && node_seen && wgt_seen))
    else begin
      $error("gat_ready rose before all three load-done levels were seen");
      fail_count++;
    end

endmodule

bind gat_top_wrapper gat_asserts u_asserts (
  .clk                        (clk),
  .arst_n                     (arst_n),
  .gat_ready                  (gat_ready),
  .start                      (start),
  .feat_wr_en                 (feat_wr_en),
  .h_data_bram_load_done      (h_data_bram_load_done),
  .h_node_info_bram_load_done (h_node_info_bram_load_done),
  .wgt_bram_load_done         (wgt_bram_load_done)
);

// ==== tests/gat_tb.sv ====
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_tb;
  import gat_pkg::*;

  localparam int NF    = `GAT_NUM_FEATURE_OUT;
  localparam int NODES = `GAT_TOTAL_NODES;
  localparam int DW    = `GAT_DATA_WIDTH;
  localparam int CW    = `GAT_COL_IDX_WIDTH;
  localparam int RLW   = `GAT_ROW_LEN_WIDTH;
  localparam int WHW   = `GAT_WH_DATA_WIDTH;
  localparam int HAB   = `GAT_H_ADDR_W + 2;
  localparam int NAB   = `GAT_NODE_ADDR_W + 2;
  localparam int WAB   = `GAT_WEIGHT_ADDR_W + 2;
  localparam int FAB   = `GAT_FEAT_ADDR_W + 2;

  // Worst case run is a full H memory with each nonzero costing NF+2 cycles
  localparam int RUN_BUDGET      = (`GAT_H_DEPTH + NODES) * (NF + 2);
  localparam int PHASE_BUDGET    = RUN_BUDGET + 2 * `GAT_H_DEPTH + 3 * `GAT_FEAT_DEPTH + 40;
  localparam int WATCHDOG_CYCLES = 6 * PHASE_BUDGET + 200;

  logic                              clk;
  logic                              arst_n;
  logic                              rst_req;
  logic                              gat_ready;
  logic [`GAT_TOP_WIDTH-1:0]         gat_debug_1;
  logic [`GAT_TOP_WIDTH-1:0]         gat_debug_2;
  logic [`GAT_TOP_WIDTH-1:0]         gat_debug_3;
  logic                              h_data_bram_load_done;
  logic                              h_node_info_bram_load_done;
  logic                              wgt_bram_load_done;
  logic [`GAT_TOP_WIDTH-1:0]         h_data_bram_din;
  logic [`GAT_TOP_WIDTH-1:0]         h_node_info_bram_din;
  logic [`GAT_TOP_WIDTH-1:0]         wgt_bram_din;
  logic                              h_data_bram_ena;
  logic                              h_data_bram_wea;
  logic                              h_node_info_bram_ena;
  logic                              h_node_info_bram_wea;
  logic                              wgt_bram_ena;
  logic                              wgt_bram_wea;
  logic [HAB-1:0]                    h_data_bram_addra;
  logic [NAB-1:0]                    h_node_info_bram_addra;
  logic [WAB-1:0]                    wgt_bram_addra;
  logic [FAB-1:0]                    feat_bram_addrb;
  logic [`GAT_NEW_FEATURE_WIDTH-1:0] feat_bram_dout;

  // Host-side images and the expected feature memory
  h_entry_t   h_img    [`GAT_H_DEPTH];
  node_info_t node_img [NODES];
  weight_t    w_img    [`GAT_WEIGHT_DEPTH];
  acc_t       exp_feat [`GAT_FEAT_DEPTH];
  int         exp_nodes;
  int         exp_nnz;
  logic [31:0] lfsr_state;
  string      cur_test;

  gat_clk_gen u_clk_gen (.*);
  gat_top_wrapper u_dut (.*);

  // ====================================================================
  // Helpers
  // ====================================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r[b] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_feat(input string what, input acc_t exp, input acc_t act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s %s expected %0d actual %0d", cur_test, what, exp, act));
    end
  endtask

  task automatic compare_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s %s expected 0x%08h actual 0x%08h",
                         cur_test, what, exp, act));
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_req                    <= 1'b1;
    h_data_bram_load_done      <= 1'b0;
    h_node_info_bram_load_done <= 1'b0;
    wgt_bram_load_done         <= 1'b0;
    feat_bram_addrb            <= '0;
    @(posedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    while (arst_n !== 1'b1) @(negedge clk);
  endtask

  // Writes all three images, with ena as given and wea always high
  task automatic load_images(input logic ena, input logic corrupt);
    logic [31:0] flip;
    flip = corrupt ? '1 : '0;
    for (int i = 0; i < `GAT_H_DEPTH; i++) begin
      @(posedge clk);
      h_data_bram_ena        <= ena;
      h_data_bram_wea        <= 1'b1;
      h_data_bram_din        <= 32'(h_img[i]) ^ flip;
      h_data_bram_addra      <= HAB'(i * 4);
      wgt_bram_ena           <= ena;
      wgt_bram_wea           <= 1'b1;
      wgt_bram_din           <= {24'b0, w_img[i % `GAT_WEIGHT_DEPTH]} ^ flip;
      wgt_bram_addra         <= WAB'((i % `GAT_WEIGHT_DEPTH) * 4);
      h_node_info_bram_ena   <= ena && (i < NODES);
      h_node_info_bram_wea   <= 1'b1;
      h_node_info_bram_din   <= 32'(node_img[i % NODES]) ^ flip;
      h_node_info_bram_addra <= NAB'((i % NODES) * 4);
    end
    @(posedge clk);
    h_data_bram_ena      <= 1'b0;
    h_data_bram_wea      <= 1'b0;
    wgt_bram_ena         <= 1'b0;
    wgt_bram_wea         <= 1'b0;
    h_node_info_bram_ena <= 1'b0;
    h_node_info_bram_wea <= 1'b0;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (gat_ready !== 1'b1 && cycles < RUN_BUDGET) begin
      @(negedge clk);
      cycles++;
    end
    if (gat_ready !== 1'b1) begin
      fail_now($sformatf("%s: gat_ready did not rise within %0d cycles", cur_test, RUN_BUDGET));
    end
  endtask

  // Reference model walking nodes from 0 until the flagged one with H consumed in order
  task automatic model_run();
    int ptr;
    int sum;
    ptr       = 0;
    exp_nodes = 0;
    exp_nnz   = 0;
    for (int n = 0; n < NODES; n++) begin
      for (int j = 0; j < NF; j++) begin
        sum = 0;
        for (int e = 0; e < node_img[n].row_len; e++) begin
          sum = sum + h_img[ptr + e].value * w_img[h_img[ptr + e].col * NF + j];
        end
        exp_feat[n * NF + j] = WHW'(sum);
      end
      ptr       = ptr + node_img[n].row_len;
      exp_nnz   = exp_nnz + node_img[n].row_len;
      exp_nodes = exp_nodes + 1;
      if (node_img[n].last) break;
    end
  endtask

  task automatic run_graph(input logic corrupt_after_load);
    reset_dut();
    load_images(1'b1, 1'b0);
    if (corrupt_after_load) load_images(1'b0, 1'b1);
    @(posedge clk);
    h_data_bram_load_done      <= 1'b1;
    h_node_info_bram_load_done <= 1'b1;
    wgt_bram_load_done         <= 1'b1;
    wait_ready();
    model_run();
  endtask

  task automatic check_features();
    logic [`GAT_NEW_FEATURE_WIDTH-1:0] data;
    acc_t got;
    for (int a = 0; a < NODES * NF; a++) begin
      @(posedge clk);
      feat_bram_addrb <= FAB'(a * 4);
      @(posedge clk);
      @(negedge clk);
      data = feat_bram_dout;
      got  = data[WHW-1:0];
      compare_feat($sformatf("feature word %0d", a), exp_feat[a], got);
      compare_word($sformatf("feature word %0d extended", a), 32'(exp_feat[a]), data);
    end
  endtask

  task automatic gen_random_graph(input int last_node);
    for (int n = 0; n < NODES; n++) begin
      node_img[n].row_len = RLW'(rand_bits(3));
      node_img[n].last    = (n == last_node);
    end
    for (int i = 0; i < `GAT_H_DEPTH; i++) begin
      h_img[i].value = DW'(rand_bits(DW));
      h_img[i].col   = CW'(rand_bits(CW));
    end
    for (int i = 0; i < `GAT_WEIGHT_DEPTH; i++) begin
      w_img[i] = DW'(rand_bits(DW));
    end
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic reset_state_test();
    cur_test = "reset_state";
    reset_dut();
    compare_word("gat_ready", '0, 32'(gat_ready));
    compare_word("gat_debug_1", '0, gat_debug_1);
    compare_word("gat_debug_2", '0, gat_debug_2);
    compare_word("gat_debug_3", '0, gat_debug_3);
    @(posedge clk);
    h_data_bram_load_done <= 1'b1;
    wgt_bram_load_done    <= 1'b1;
    repeat (20) begin
      @(negedge clk);
      compare_word("gat_ready with two loads", '0, 32'(gat_ready));
    end
    compare_word("gat_debug_3 with two loads", '0, gat_debug_3);
  endtask

  task automatic random_graph_test();
    cur_test = "random_graph";
    gen_random_graph(NODES - 1);
    run_graph(1'b0);
    check_features();
  endtask

  task automatic zero_rows_test();
    cur_test = "zero_rows";
    // All-empty pass first, so every feature word holds zero
    for (int n = 0; n < NODES; n++) begin
      node_img[n].row_len = '0;
      node_img[n].last    = (n == NODES - 1);
    end
    run_graph(1'b0);
    check_features();
    gen_random_graph(3);
    node_img[1].row_len = '0;
    node_img[2].row_len = '0;
    run_graph(1'b0);
    check_features();
  endtask

  task automatic debug_counter_test();
    cur_test = "debug_counters";
    gen_random_graph(5);
    run_graph(1'b0);
    compare_word("gat_debug_1", 32'(exp_nodes), gat_debug_1);
    compare_word("gat_debug_2", 32'(exp_nnz), gat_debug_2);
    if (gat_debug_3 == '0 || $isunknown(gat_debug_3)) begin
      fail_now($sformatf("%s: gat_debug_3 stayed zero through a run", cur_test));
    end
  endtask

  task automatic ena_gating_test();
    cur_test = "ena_gating";
    gen_random_graph(NODES - 1);
    run_graph(1'b1);
    check_features();
  endtask

  // ====================================================================
  // Main sequence, assertion monitor and watchdog
  // ====================================================================
  initial begin
    rst_req                    = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    feat_bram_addrb            = '0;
    lfsr_state                 = 32'hfa68a21d;
    cur_test                   = "init";

    reset_state_test();
    random_graph_test();
    zero_rows_test();
    debug_counter_test();
    ena_gating_test();

    @(negedge clk);
    if (u_dut.u_asserts.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_now("A bound assertion failed during the run");
    end
  end

  always @(negedge clk) begin
    if (u_dut.u_asserts.fail_count != 0) begin
      fail_now($sformatf("%s: a bound assertion failed, see the error above", cur_test));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_now($sformatf("Timeout after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test));
  end

endmodule

// ==== gat_lite.f ====
+incdir+include
rtl/gat_pkg.sv
rtl/gat_bram_store.sv
rtl/gat_status_regs.sv
rtl/gat_spmm_core.sv
rtl/gat_feat_bram.sv
rtl/gat_top_wrapper.sv
tests/gat_clk_gen.sv
tests/gat_asserts.sv
tests/gat_tb.sv
